/* hw/pipe_pkg.sv */
package pipe_pkg;

    localparam int DATA_W = 32;

    // data_size encoding on the data port
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        LD_B   = 4'h1,
        LD_BU  = 4'h2,
        LD_H   = 4'h3,
        LD_HU  = 4'h4,
        LD_W   = 4'h5,
        ST_B   = 4'h6,
        ST_H   = 4'h7,
        ST_W   = 4'h8
    } mem_op_e;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        mem_op_e           op;
        logic [DATA_W-1:0] result;
        logic [4:0]        rd;
        logic              we;
        logic              ale;
    } es_payload_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic              we;
        logic [4:0]        rd;
        logic [DATA_W-1:0] wdata;
        logic              ale;
    } ms_payload_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {ST_B, ST_H, ST_W};
    endfunction

endpackage

/* hw/stage_if.sv */
`timescale 1ns/1ps

interface stage_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     allowin;
    payload_t payload;

    // sending stage
    modport upstream (
        output valid,
        output payload,
        input  allowin
    );

    // receiving stage
    modport downstream (
        input  valid,
        input  payload,
        output allowin
    );

endinterface

/* hw/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [pipe_pkg::DATA_W-1:0]   in_pc,
    input  pipe_pkg::mem_op_e             in_op,
    input  logic [pipe_pkg::DATA_W-1:0]   in_base,
    input  logic [pipe_pkg::DATA_W-1:0]   in_offset,
    input  logic [pipe_pkg::DATA_W-1:0]   in_wdata,
    input  logic [4:0]                    in_rd,
    output logic                          data_req,
    output logic                          data_wr,
    output logic [1:0]                    data_size,
    output logic [3:0]                    data_wstrb,
    output logic [pipe_pkg::DATA_W-1:0]   data_addr,
    output logic [pipe_pkg::DATA_W-1:0]   data_wdata,
    input  logic                          data_addr_ok,
    stage_if.upstream                     out
);

    logic                        es_valid;
    logic [pipe_pkg::DATA_W-1:0] es_pc;
    pipe_pkg::mem_op_e           es_op;
    logic [pipe_pkg::DATA_W-1:0] es_base;
    logic [pipe_pkg::DATA_W-1:0] es_offset;
    logic [pipe_pkg::DATA_W-1:0] es_wdata;
    logic [4:0]                  es_rd;
    logic [pipe_pkg::DATA_W-1:0] es_addr;
    logic                        es_load;
    logic                        es_store;
    logic                        es_ale;
    logic                        es_need_req;
    logic                        es_ready_go;
    pipe_pkg::es_payload_t       es_out;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (in_ready) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            es_pc     <= in_pc;
            es_op     <= in_op;
            es_base   <= in_base;
            es_offset <= in_offset;
            es_wdata  <= in_wdata;
            es_rd     <= in_rd;
        end
    end

    assign es_addr  = es_base + es_offset;
    assign es_load  = pipe_pkg::is_load(es_op);
    assign es_store = pipe_pkg::is_store(es_op);

    always_comb begin
        case (es_op)
            pipe_pkg::LD_H, pipe_pkg::LD_HU, pipe_pkg::ST_H: es_ale = es_addr[0];
            pipe_pkg::LD_W, pipe_pkg::ST_W:                  es_ale = |es_addr[1:0];
            default:                                         es_ale = 1'b0;
        endcase
    end

    // size, lane-replicated store data and byte strobes
    always_comb begin
        data_size  = pipe_pkg::SIZE_W;
        data_wdata = es_wdata;
        data_wstrb = 4'b0000;
        case (es_op)
            pipe_pkg::LD_B, pipe_pkg::LD_BU: begin
                data_size = pipe_pkg::SIZE_B;
            end
            pipe_pkg::LD_H, pipe_pkg::LD_HU: begin
                data_size = pipe_pkg::SIZE_H;
            end
            pipe_pkg::ST_B: begin
                data_size  = pipe_pkg::SIZE_B;
                data_wdata = {4{es_wdata[7:0]}};
                data_wstrb = 4'b0001 << es_addr[1:0];
            end
            pipe_pkg::ST_H: begin
                data_size  = pipe_pkg::SIZE_H;
                data_wdata = {2{es_wdata[15:0]}};
                data_wstrb = es_addr[1] ? 4'b1100 : 4'b0011;
            end
            pipe_pkg::ST_W: begin
                data_wstrb = 4'b1111;
            end
            default: begin
                data_size = pipe_pkg::SIZE_W;
            end
        endcase
    end

    // request only once the memory stage can take the item
    assign es_need_req = (es_load | es_store) & ~es_ale;
    assign data_req    = es_valid & es_need_req & out.allowin;
    assign data_wr     = es_store;
    assign data_addr   = es_addr;

    assign es_ready_go = ~es_need_req | (data_req & data_addr_ok);
    assign in_ready    = ~es_valid | (es_ready_go & out.allowin);

    assign es_out.pc     = es_pc;
    assign es_out.op     = es_op;
    assign es_out.result = es_addr;
    assign es_out.rd     = es_rd;
    assign es_out.we     = (es_load | (es_op == pipe_pkg::OP_ADD)) & ~es_ale;
    assign es_out.ale    = es_ale;

    assign out.valid   = es_valid & es_ready_go;
    assign out.payload = es_out;

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        data_data_ok,
    input  logic [pipe_pkg::DATA_W-1:0] data_rdata,
    stage_if.downstream                 in,
    stage_if.upstream                   out
);

    logic                        ms_valid;
    logic                        ms_ready_go;
    logic                        ms_req_issued;
    pipe_pkg::es_payload_t       ms_r;
    logic                        buf_valid;
    logic [pipe_pkg::DATA_W-1:0] data_buf;
    logic [pipe_pkg::DATA_W-1:0] rdata;
    logic [pipe_pkg::DATA_W-1:0] shifted;
    logic [pipe_pkg::DATA_W-1:0] ms_wdata;
    logic                        ms_leave;
    logic                        catch_data;
    pipe_pkg::ms_payload_t       ms_out;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (in.allowin) begin
            ms_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            ms_r <= in.payload;
        end
    end

    // a request went out for every aligned load or store
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_req_issued <= 1'b0;
        end else if (in.valid && in.allowin) begin
            ms_req_issued <= (pipe_pkg::is_load(in.payload.op)
                              | pipe_pkg::is_store(in.payload.op))
                             & ~in.payload.ale;
        end
    end

    assign ms_leave   = out.valid & out.allowin;
    assign catch_data = ms_valid & ms_req_issued & data_data_ok & ~buf_valid;

    // hold read data that arrives while stalled
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (ms_leave) begin
            buf_valid <= 1'b0;
        end else if (catch_data) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (catch_data) begin
            data_buf <= data_rdata;
        end
    end

    assign ms_ready_go = ~ms_req_issued | buf_valid | data_data_ok;
    assign in.allowin  = ~ms_valid | (ms_ready_go & out.allowin);
    assign out.valid   = ms_valid & ms_ready_go;

    assign rdata   = buf_valid ? data_buf : data_rdata;
    assign shifted = rdata >> {ms_r.result[1:0], 3'b000};

    always_comb begin
        case (ms_r.op)
            pipe_pkg::LD_B:  ms_wdata = {{24{shifted[7]}}, shifted[7:0]};
            pipe_pkg::LD_BU: ms_wdata = {24'b0, shifted[7:0]};
            pipe_pkg::LD_H:  ms_wdata = {{16{shifted[15]}}, shifted[15:0]};
            pipe_pkg::LD_HU: ms_wdata = {16'b0, shifted[15:0]};
            pipe_pkg::LD_W:  ms_wdata = rdata;
            // add result or store address
            default:         ms_wdata = ms_r.result;
        endcase
    end

    assign ms_out.pc    = ms_r.pc;
    assign ms_out.we    = ms_r.we & ~ms_r.ale;
    assign ms_out.rd    = ms_r.rd;
    assign ms_out.wdata = ms_wdata;
    assign ms_out.ale   = ms_r.ale;

    assign out.payload = ms_out;

endmodule

/* hw/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic                        clk,
    input  logic                        resetn,
    stage_if.downstream                 in,
    input  logic                        retire_ready,
    output logic                        retire_valid,
    output logic [pipe_pkg::DATA_W-1:0] retire_pc,
    output logic                        retire_we,
    output logic [4:0]                  retire_waddr,
    output logic [pipe_pkg::DATA_W-1:0] retire_wdata,
    output logic                        retire_ale
);

    logic                  ws_valid;
    pipe_pkg::ms_payload_t ws_r;

    // take a new item when empty or when the held one retires
    assign in.allowin = ~ws_valid | retire_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (in.allowin) begin
            ws_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            ws_r <= in.payload;
        end
    end

    assign retire_valid = ws_valid;
    assign retire_pc    = ws_r.pc;
    // r0 is never written
    assign retire_we    = ws_r.we & (ws_r.rd != 5'd0);
    assign retire_waddr = ws_r.rd;
    assign retire_wdata = ws_r.wdata;
    assign retire_ale   = ws_r.ale;

endmodule

/* hw/mem_pipe_top.sv */
`timescale 1ns/1ps

module mem_pipe_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [pipe_pkg::DATA_W-1:0] in_pc,
    input  pipe_pkg::mem_op_e           in_op,
    input  logic [pipe_pkg::DATA_W-1:0] in_base,
    input  logic [pipe_pkg::DATA_W-1:0] in_offset,
    input  logic [pipe_pkg::DATA_W-1:0] in_wdata,
    input  logic [4:0]                  in_rd,
    output logic                        data_req,
    output logic                        data_wr,
    output logic [1:0]                  data_size,
    output logic [3:0]                  data_wstrb,
    output logic [pipe_pkg::DATA_W-1:0] data_addr,
    output logic [pipe_pkg::DATA_W-1:0] data_wdata,
    input  logic                        data_addr_ok,
    input  logic                        data_data_ok,
    input  logic [pipe_pkg::DATA_W-1:0] data_rdata,
    output logic                        retire_valid,
    input  logic                        retire_ready,
    output logic [pipe_pkg::DATA_W-1:0] retire_pc,
    output logic                        retire_we,
    output logic [4:0]                  retire_waddr,
    output logic [pipe_pkg::DATA_W-1:0] retire_wdata,
    output logic                        retire_ale
);

    stage_if #(.payload_t(pipe_pkg::es_payload_t)) es2ms ();
    stage_if #(.payload_t(pipe_pkg::ms_payload_t)) ms2ws ();

    ex_stage u_ex (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (in_pc),
        .in_op        (in_op),
        .in_base      (in_base),
        .in_offset    (in_offset),
        .in_wdata     (in_wdata),
        .in_rd        (in_rd),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .out          (es2ms.upstream)
    );

    mem_stage u_mem (
        .clk          (clk),
        .resetn       (resetn),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .in           (es2ms.downstream),
        .out          (ms2ws.upstream)
    );

    wb_stage u_wb (
        .clk          (clk),
        .resetn       (resetn),
        .in           (ms2ws.downstream),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_waddr (retire_waddr),
        .retire_wdata (retire_wdata),
        .retire_ale   (retire_ale)
    );

endmodule

/* sim/mem_pipe_props.sv */
`timescale 1ns/1ps

module mem_pipe_props (
    input logic                        clk,
    input logic                        resetn,
    input logic                        data_req,
    input logic                        data_wr,
    input logic [1:0]                  data_size,
    input logic [3:0]                  data_wstrb,
    input logic [pipe_pkg::DATA_W-1:0] data_addr,
    input logic [pipe_pkg::DATA_W-1:0] data_wdata,
    input logic                        data_addr_ok,
    input logic                        data_data_ok,
    input logic                        retire_valid,
    input logic                        retire_ready,
    input logic [pipe_pkg::DATA_W-1:0] retire_pc,
    input logic                        retire_we,
    input logic [4:0]                  retire_waddr,
    input logic [pipe_pkg::DATA_W-1:0] retire_wdata,
    input logic                        retire_ale
);

    int outstanding;
    int fail_count = 0;

    // accepted requests still waiting for data_ok
    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(data_req && data_addr_ok) - int'(data_data_ok);
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr) && $stable(data_wr)
            && $stable(data_size) && $stable(data_wstrb) && $stable(data_wdata))
        else begin
            $error("data request dropped or changed before addr_ok");
            fail_count++;
        end

    a_retire_hold: assert property (@(posedge clk) disable iff (!resetn)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
            && $stable(retire_we) && $stable(retire_waddr) && $stable(retire_wdata)
            && $stable(retire_ale))
        else begin
            $error("retire outputs changed while stalled");
            fail_count++;
        end

    // the memory stage's request plus one new one at most
    a_req_limit: assert property (@(posedge clk) disable iff (!resetn)
        data_req && data_addr_ok |-> outstanding < 2)
        else begin
            $error("request accepted with two requests still waiting for data_ok");
            fail_count++;
        end

    // misaligned halfword or word never reaches the bus
    a_aligned_req: assert property (@(posedge clk) disable iff (!resetn)
        data_req |-> !((data_size == pipe_pkg::SIZE_H && data_addr[0])
            || (data_size == pipe_pkg::SIZE_W && data_addr[1:0] != 2'b00)))
        else begin
            $error("request issued for a misaligned address");
            fail_count++;
        end

endmodule

bind mem_pipe_top mem_pipe_props i_props (
    .clk          (clk),
    .resetn       (resetn),
    .data_req     (data_req),
    .data_wr      (data_wr),
    .data_size    (data_size),
    .data_wstrb   (data_wstrb),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_addr_ok (data_addr_ok),
    .data_data_ok (data_data_ok),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_pc    (retire_pc),
    .retire_we    (retire_we),
    .retire_waddr (retire_waddr),
    .retire_wdata (retire_wdata),
    .retire_ale   (retire_ale)
);

/* sim/tb_mem_pipe.sv */
`timescale 1ns/1ps

module tb_mem_pipe;

    localparam int N_DIRECTED = 22;
    localparam int N_RAND     = 300;
    localparam int N_OPS      = N_DIRECTED + N_RAND;

    logic                        clk          = 1'b0;
    logic                        resetn       = 1'b0;
    logic                        in_valid     = 1'b0;
    logic                        in_ready;
    logic [pipe_pkg::DATA_W-1:0] in_pc        = '0;
    pipe_pkg::mem_op_e           in_op        = pipe_pkg::OP_ADD;
    logic [pipe_pkg::DATA_W-1:0] in_base      = '0;
    logic [pipe_pkg::DATA_W-1:0] in_offset    = '0;
    logic [pipe_pkg::DATA_W-1:0] in_wdata     = '0;
    logic [4:0]                  in_rd        = '0;
    logic                        data_req;
    logic                        data_wr;
    logic [1:0]                  data_size;
    logic [3:0]                  data_wstrb;
    logic [pipe_pkg::DATA_W-1:0] data_addr;
    logic [pipe_pkg::DATA_W-1:0] data_wdata;
    logic                        data_addr_ok = 1'b0;
    logic                        data_data_ok = 1'b0;
    logic [pipe_pkg::DATA_W-1:0] data_rdata   = '0;
    logic                        retire_valid;
    logic                        retire_ready = 1'b0;
    logic [pipe_pkg::DATA_W-1:0] retire_pc;
    logic                        retire_we;
    logic [4:0]                  retire_waddr;
    logic [pipe_pkg::DATA_W-1:0] retire_wdata;
    logic                        retire_ale;

    integer                seed         = 11;
    int                    errors       = 0;
    int                    issued       = 0;
    int                    retired      = 0;
    int                    req_count    = 0;
    int                    req_expected = 0;
    logic [31:0]           pc           = 32'h1c00_0000;
    logic [31:0]           mem [64];
    logic [31:0]           shadow [64];
    logic [31:0]           resp_data [$];
    int                    resp_wait [$];
    logic [1:0]            size_expected [$];
    pipe_pkg::ms_payload_t expected [$];

    mem_pipe_top i_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] fill_word(input int idx);
        return (32'h9e37_79b9 * (idx + 1)) ^ {idx[7:0], 24'h00_0000};
    endfunction

    // bytes moved by one access
    function automatic logic [1:0] access_size(input pipe_pkg::mem_op_e op);
        case (op)
            pipe_pkg::LD_B, pipe_pkg::LD_BU, pipe_pkg::ST_B: return pipe_pkg::SIZE_B;
            pipe_pkg::LD_H, pipe_pkg::LD_HU, pipe_pkg::ST_H: return pipe_pkg::SIZE_H;
            default:                                         return pipe_pkg::SIZE_W;
        endcase
    endfunction

    always @(posedge clk) begin
        retire_ready <= ($random(seed) & 3) != 0;
    end

    // data memory with random addr_ok and in-order data_ok after 1 to 3 cycles
    always @(posedge clk) begin
        int idx;
        if (!resetn) begin
            data_addr_ok <= 1'b0;
            data_data_ok <= 1'b0;
            for (int i = 0; i < 64; i++) begin
                mem[i] = fill_word(i);
            end
        end else begin
            data_addr_ok <= $random(seed) & 1;
            if (data_req && data_addr_ok) begin
                if (size_expected.size() > 0) begin
                    assert (data_size == size_expected[0])
                        else report_mismatch("data_size", size_expected[0], data_size);
                    void'(size_expected.pop_front());
                end
                idx = data_addr[7:2];
                for (int b = 0; b < 4; b++) begin
                    if (data_wr && data_wstrb[b]) begin
                        mem[idx][8*b +: 8] = data_wdata[8*b +: 8];
                    end
                end
                resp_data.push_back(mem[idx]);
                resp_wait.push_back(($random(seed) & 32'h7fff) % 3);
                req_count++;
            end
            data_data_ok <= 1'b0;
            if (resp_data.size() > 0) begin
                if (resp_wait[0] == 0) begin
                    data_data_ok <= 1'b1;
                    data_rdata   <= resp_data.pop_front();
                    void'(resp_wait.pop_front());
                end else begin
                    resp_wait[0] = resp_wait[0] - 1;
                end
            end
        end
    end

    // expected retire from the operation rules and the shadow memory
    task automatic predict(input pipe_pkg::mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wd, input logic [4:0] rd);
        pipe_pkg::ms_payload_t e;
        logic [31:0]           word;
        logic [7:0]            b;
        logic [15:0]           h;
        int                    idx;
        idx  = addr[7:2];
        word = shadow[idx];
        b    = word[8*addr[1:0] +: 8];
        h    = addr[1] ? word[31:16] : word[15:0];
        e.pc    = pc;
        e.rd    = rd;
        e.wdata = addr;
        e.we    = 1'b0;
        e.ale   = ((op inside {pipe_pkg::LD_H, pipe_pkg::LD_HU, pipe_pkg::ST_H}) && addr[0])
                  || ((op inside {pipe_pkg::LD_W, pipe_pkg::ST_W}) && addr[1:0] != 2'b00);
        if (!e.ale) begin
            if (op != pipe_pkg::OP_ADD) begin
                req_expected++;
                size_expected.push_back(access_size(op));
            end
            case (op)
                pipe_pkg::LD_B:  e.wdata = {{24{b[7]}}, b};
                pipe_pkg::LD_BU: e.wdata = {24'h00_0000, b};
                pipe_pkg::LD_H:  e.wdata = {{16{h[15]}}, h};
                pipe_pkg::LD_HU: e.wdata = {16'h0000, h};
                pipe_pkg::LD_W:  e.wdata = word;
                pipe_pkg::ST_B:  shadow[idx][8*addr[1:0] +: 8] = wd[7:0];
                pipe_pkg::ST_H:  shadow[idx][16*addr[1] +: 16] = wd[15:0];
                pipe_pkg::ST_W:  shadow[idx] = wd;
                default:         e.wdata = addr;
            endcase
            e.we = !(op inside {pipe_pkg::ST_B, pipe_pkg::ST_H, pipe_pkg::ST_W}) && rd != 5'd0;
        end
        expected.push_back(e);
    endtask

    task automatic issue(input pipe_pkg::mem_op_e op, input logic [31:0] base,
                         input logic [31:0] off, input logic [31:0] wd, input logic [4:0] rd);
        predict(op, base + off, wd, rd);
        in_valid  <= 1'b1;
        in_pc     <= pc;
        in_op     <= op;
        in_base   <= base;
        in_offset <= off;
        in_wdata  <= wd;
        in_rd     <= rd;
        pc = pc + 4;
        do @(posedge clk); while (!in_ready);
        issued++;
    endtask

    task automatic issue_random();
        pipe_pkg::mem_op_e op;
        logic [31:0]       addr;
        logic [31:0]       off;
        op   = pipe_pkg::mem_op_e'(($random(seed) & 32'h7fff_ffff) % 9);
        // sixteen words so stores and loads collide
        addr = $random(seed) & 32'h3f;
        if (($random(seed) & 3) != 0) begin
            if (op inside {pipe_pkg::LD_H, pipe_pkg::LD_HU, pipe_pkg::ST_H}) begin
                addr[0] = 1'b0;
            end
            if (op inside {pipe_pkg::LD_W, pipe_pkg::ST_W}) begin
                addr[1:0] = 2'b00;
            end
        end
        off = $random(seed) & 32'hff;
        issue(op, addr - off, off, $random(seed), $random(seed));
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp_v, act_v);
        errors++;
    endtask

    // scoreboard
    always @(posedge clk) begin
        pipe_pkg::ms_payload_t e;
        if (resetn && retire_valid && retire_ready) begin
            assert (expected.size() > 0)
                else begin
                    $display("retire at %0t with no operation outstanding", $time);
                    errors++;
                end
            if (expected.size() > 0) begin
                e = expected.pop_front();
                retired++;
                assert (retire_pc == e.pc) else report_mismatch("retire_pc", e.pc, retire_pc);
                assert (retire_we == e.we) else report_mismatch("retire_we", e.we, retire_we);
                assert (retire_waddr == e.rd)
                    else report_mismatch("retire_waddr", e.rd, retire_waddr);
                assert (retire_ale == e.ale) else report_mismatch("retire_ale", e.ale, retire_ale);
                // wdata only matters when the register is written
                assert (!e.we || retire_wdata == e.wdata)
                    else report_mismatch("retire_wdata", e.wdata, retire_wdata);
            end
        end
    end

    initial begin
        for (int i = 0; i < 64; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        issue(pipe_pkg::ST_W, 32'h40, 32'h20, 32'hcafe_f00d, 5'd3);
        issue(pipe_pkg::LD_W, 32'h60, 32'h0, 32'h0, 5'd4);
        for (int k = 0; k < 4; k++) begin
            issue(pipe_pkg::LD_B, 32'h20, k, 32'h0, 5'd5);
            issue(pipe_pkg::LD_BU, 32'h20, k, 32'h0, 5'd6);
            if (k % 2 == 0) begin
                issue(pipe_pkg::LD_H, 32'h20, k, 32'h0, 5'd7);
                issue(pipe_pkg::LD_HU, 32'h20, k, 32'h0, 5'd8);
            end
        end
        // partial stores then a full word read
        issue(pipe_pkg::ST_B, 32'h30, 32'h1, 32'h0000_00a5, 5'd0);
        issue(pipe_pkg::ST_H, 32'h30, 32'h2, 32'h0000_8e71, 5'd0);
        issue(pipe_pkg::LD_W, 32'h30, 32'h0, 32'h0, 5'd9);
        issue(pipe_pkg::OP_ADD, 32'h1234_0000, 32'h0000_5678, 32'h0, 5'd0);
        issue(pipe_pkg::OP_ADD, 32'hffff_fff0, 32'h0000_0020, 32'h0, 5'd10);
        issue(pipe_pkg::LD_H, 32'h10, 32'h1, 32'h0, 5'd11);
        issue(pipe_pkg::LD_W, 32'h20, 32'h2, 32'h0, 5'd12);
        issue(pipe_pkg::ST_W, 32'h10, 32'h3, 32'h5555_aaaa, 5'd0);
        for (int n = 0; n < N_RAND; n++) begin
            if (($random(seed) & 7) == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            issue_random();
        end
        in_valid <= 1'b0;
        wait (retired == issued);
        repeat (4) @(posedge clk);
        assert (req_count == req_expected)
            else begin
                $display("%0d data requests seen but %0d aligned memory operations issued",
                         req_count, req_expected);
                errors++;
            end
        errors = errors + i_dut.i_props.fail_count;
        $display("%0d operations retired, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (N_OPS * 20 + 5) @(posedge clk);
        $display("timeout with only %0d of %0d operations retired", retired, N_OPS);
        $display("Verification failed");
        $finish;
    end

endmodule

/* project.f */
hw/pipe_pkg.sv
hw/stage_if.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_pipe_top.sv
sim/mem_pipe_props.sv
sim/tb_mem_pipe.sv
